/* cpu.f */
logic/rv32i_pkg.sv
logic/regfile.sv
logic/ir.sv
logic/alu.sv
logic/cmp.sv
logic/datapath.sv
logic/control.sv
logic/cpu.sv
tb/cpu_props.sv
tb/cpu_tb.sv

/* logic/alu.sv */
module alu
import rv32i_pkg::*;
(
    input  alu_ops    aluop,
    input  rv32i_word a,
    input  rv32i_word b,
    output rv32i_word f
);

    logic [4:0] shamt;

    // shift amount is the low five bits only
    assign shamt = b[4:0];

    always_comb begin
        unique case (aluop)
            alu_add: f = a + b;
            alu_sll: f = a << shamt;
            // arithmetic shift keeps the sign
            alu_sra: f = $signed(a) >>> shamt;
            alu_sub: f = a - b;
            alu_xor: f = a ^ b;
            alu_srl: f = a >> shamt;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = a + b;
        endcase
    end

endmodule : alu

/* logic/cmp.sv */
module cmp
import rv32i_pkg::*;
(
    input  branch_funct3_t cmpop,
    input  rv32i_word      a,
    input  rv32i_word      b,
    output logic           f
);

    // blt and bltu also serve slt and sltu
    always_comb begin
        case (cmpop)
            beq:     f = (a == b);
            bne:     f = (a != b);
            blt:     f = ($signed(a) < $signed(b));
            bge:     f = ($signed(a) >= $signed(b));
            bltu:    f = (a < b);
            bgeu:    f = (a >= b);
            default: f = 1'b0;
        endcase
    end

endmodule : cmp

/* logic/control.sv */
module control
import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  rv32i_opcode     opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic            br_en,
    input  logic [1:0]      mar_low,
    input  logic            mem_resp,
    output pcmux_sel_t      pcmux_sel,
    output alumux1_sel_t    alumux1_sel,
    output alumux2_sel_t    alumux2_sel,
    output regfilemux_sel_t regfilemux_sel,
    output marmux_sel_t     marmux_sel,
    output cmpmux_sel_t     cmpmux_sel,
    output alu_ops          aluop,
    output branch_funct3_t  cmpop,
    output logic            load_pc,
    output logic            load_ir,
    output logic            load_regfile,
    output logic            load_mar,
    output logic            load_mdr,
    output logic            load_data_out,
    output logic            mem_read,
    output logic            mem_write,
    output logic [3:0]      mem_byte_enable
);

    ctrl_state_t state, next_state;
    alu_ops      arith_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch1;
        end else begin
            state <= next_state;
        end
    end

    // funct3 maps straight onto the alu op except for the sub and sra variants
    always_comb begin
        arith_op = alu_ops'(funct3);
        if (arith_funct3_t'(funct3) == sr) begin
            arith_op = funct7[5] ? alu_sra : alu_srl;
        end
    end

    always_comb begin
        // defaults hold everything
        next_state     = state;
        pcmux_sel      = pcmux_pc_plus4;
        alumux1_sel    = alumux1_rs1_out;
        alumux2_sel    = alumux2_i_imm;
        regfilemux_sel = regfilemux_alu_out;
        marmux_sel     = marmux_pc_out;
        cmpmux_sel     = cmpmux_rs2_out;
        aluop          = alu_add;
        cmpop          = branch_funct3_t'(funct3);
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_data_out  = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mem_byte_enable = 4'b1111;

        case (state)
            fetch1: begin
                load_mar   = 1'b1;
                next_state = fetch2;
            end
            // request held until the response pulse
            fetch2: begin
                mem_read = 1'b1;
                load_mdr = mem_resp;
                if (mem_resp) begin
                    next_state = fetch3;
                end
            end
            fetch3: begin
                load_ir    = 1'b1;
                next_state = decode;
            end
            decode: begin
                case (opcode)
                    op_imm:   next_state = s_imm;
                    op_reg:   next_state = s_reg;
                    op_lui:   next_state = s_lui;
                    op_auipc: next_state = s_auipc;
                    op_br:    next_state = s_br;
                    op_jal:   next_state = s_jal;
                    op_jalr:  next_state = s_jalr;
                    op_load:  next_state = calc_addr;
                    op_store: next_state = calc_addr;
                    default: begin
                        // unsupported opcode runs as a nop
                        load_pc    = 1'b1;
                        next_state = fetch1;
                    end
                endcase
            end
            s_imm, s_reg: begin
                load_pc      = 1'b1;
                load_regfile = 1'b1;
                aluop        = arith_op;
                if (state == s_reg) begin
                    alumux2_sel = alumux2_rs2_out;
                    if (arith_funct3_t'(funct3) == add && funct7[5]) begin
                        aluop = alu_sub;
                    end
                end else begin
                    cmpmux_sel = cmpmux_i_imm;
                end
                // set-less-than goes through the comparator
                if (arith_funct3_t'(funct3) == slt) begin
                    cmpop          = blt;
                    regfilemux_sel = regfilemux_br_en;
                end else if (arith_funct3_t'(funct3) == sltu) begin
                    cmpop          = bltu;
                    regfilemux_sel = regfilemux_br_en;
                end
                next_state = fetch1;
            end
            s_lui: begin
                load_pc        = 1'b1;
                load_regfile   = 1'b1;
                regfilemux_sel = regfilemux_u_imm;
                next_state     = fetch1;
            end
            s_auipc: begin
                load_pc      = 1'b1;
                load_regfile = 1'b1;
                alumux1_sel  = alumux1_pc_out;
                alumux2_sel  = alumux2_u_imm;
                next_state   = fetch1;
            end
            // target is pc + b_imm, taken only on br_en
            s_br: begin
                load_pc     = 1'b1;
                alumux1_sel = alumux1_pc_out;
                alumux2_sel = alumux2_b_imm;
                pcmux_sel   = br_en ? pcmux_alu_out : pcmux_pc_plus4;
                next_state  = fetch1;
            end
            s_jal: begin
                load_pc        = 1'b1;
                load_regfile   = 1'b1;
                regfilemux_sel = regfilemux_pc_plus4;
                alumux1_sel    = alumux1_pc_out;
                alumux2_sel    = alumux2_j_imm;
                pcmux_sel      = pcmux_alu_out;
                next_state     = fetch1;
            end
            s_jalr: begin
                load_pc        = 1'b1;
                load_regfile   = 1'b1;
                regfilemux_sel = regfilemux_pc_plus4;
                pcmux_sel      = pcmux_alu_mod2;
                next_state     = fetch1;
            end
            calc_addr: begin
                load_mar   = 1'b1;
                marmux_sel = marmux_alu_out;
                if (opcode == op_store) begin
                    alumux2_sel   = alumux2_s_imm;
                    load_data_out = 1'b1;
                    next_state    = st1;
                end else begin
                    next_state = ld1;
                end
            end
            ld1: begin
                mem_read = 1'b1;
                load_mdr = mem_resp;
                if (mem_resp) begin
                    next_state = ld2;
                end
            end
            ld2: begin
                load_pc      = 1'b1;
                load_regfile = 1'b1;
                case (load_funct3_t'(funct3))
                    lb:      regfilemux_sel = regfilemux_lb;
                    lbu:     regfilemux_sel = regfilemux_lbu;
                    lh:      regfilemux_sel = regfilemux_lh;
                    lhu:     regfilemux_sel = regfilemux_lhu;
                    default: regfilemux_sel = regfilemux_lw;
                endcase
                next_state = fetch1;
            end
            st1: begin
                mem_write = 1'b1;
                // byte enables follow the width and the low address bits
                case (store_funct3_t'(funct3))
                    sb:      mem_byte_enable = 4'b0001 << mar_low;
                    sh:      mem_byte_enable = 4'b0011 << mar_low;
                    default: mem_byte_enable = 4'b1111;
                endcase
                if (mem_resp) begin
                    load_pc    = 1'b1;
                    next_state = fetch1;
                end
            end
            default: next_state = fetch1;
        endcase
    end

endmodule : control

/* logic/cpu.sv */
module cpu
import rv32i_pkg::*;
#(
    parameter rv32i_word reset_pc = 32'h4000_0000
)
(
    input  logic       clk,
    input  logic       rst,
    input  rv32i_word  mem_rdata,
    input  logic       mem_resp,
    output rv32i_word  mem_address,
    output rv32i_word  mem_wdata,
    output logic       mem_read,
    output logic       mem_write,
    output logic [3:0] mem_byte_enable
);

    // control to datapath
    pcmux_sel_t      pcmux_sel;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    regfilemux_sel_t regfilemux_sel;
    marmux_sel_t     marmux_sel;
    cmpmux_sel_t     cmpmux_sel;
    alu_ops          aluop;
    branch_funct3_t  cmpop;
    logic            load_pc, load_ir, load_regfile;
    logic            load_mar, load_mdr, load_data_out;

    // datapath to control
    rv32i_opcode     opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            br_en;
    logic [1:0]      mar_low;

    control i_control (.*);

    datapath #(
        .reset_pc (reset_pc)
    ) i_datapath (.*);

endmodule : cpu

/* logic/datapath.sv */
module datapath
import rv32i_pkg::*;
#(
    parameter rv32i_word reset_pc = 32'h4000_0000
)
(
    input  logic            clk,
    input  logic            rst,

    // selects and enables from control
    input  pcmux_sel_t      pcmux_sel,
    input  alumux1_sel_t    alumux1_sel,
    input  alumux2_sel_t    alumux2_sel,
    input  regfilemux_sel_t regfilemux_sel,
    input  marmux_sel_t     marmux_sel,
    input  cmpmux_sel_t     cmpmux_sel,
    input  alu_ops          aluop,
    input  branch_funct3_t  cmpop,
    input  logic            load_pc,
    input  logic            load_ir,
    input  logic            load_regfile,
    input  logic            load_mar,
    input  logic            load_mdr,
    input  logic            load_data_out,

    // status back to control
    output rv32i_opcode     opcode,
    output logic [2:0]      funct3,
    output logic [6:0]      funct7,
    output logic            br_en,
    output logic [1:0]      mar_low,

    // memory side
    input  rv32i_word       mem_rdata,
    output rv32i_word       mem_address,
    output rv32i_word       mem_wdata
);

    rv32i_reg  rs1, rs2, rd;
    rv32i_word rs1_out, rs2_out, pc_out, pc_plus4, alu_out, mdr_out, ld_shift;
    rv32i_word i_imm, s_imm, b_imm, u_imm, j_imm;
    rv32i_word pcmux_out, alumux1_out, alumux2_out, regfilemux_out, marmux_out, cmpmux_out;

    regfile i_regfile (
        .clk, .rst,
        .load  (load_regfile),
        .in    (regfilemux_out),
        .src_a (rs1),
        .src_b (rs2),
        .dest  (rd),
        .reg_a (rs1_out),
        .reg_b (rs2_out)
    );

    // ir is fed from the mdr, loaded in fetch3
    ir i_ir (
        .clk, .rst,
        .load (load_ir),
        .in   (mdr_out),
        .opcode, .funct3, .funct7, .rs1, .rs2, .rd,
        .i_imm, .s_imm, .b_imm, .u_imm, .j_imm
    );

    alu i_alu (
        .aluop,
        .a (alumux1_out),
        .b (alumux2_out),
        .f (alu_out)
    );

    cmp i_cmp (
        .cmpop,
        .a (rs1_out),
        .b (cmpmux_out),
        .f (br_en)
    );

    // pc starts at the first fetch address
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_out <= reset_pc;
        end else if (load_pc) begin
            pc_out <= pcmux_out;
        end
    end

    always_ff @(posedge clk) begin
        if (load_mar) begin
            mem_address <= marmux_out;
        end
        if (load_mdr) begin
            mdr_out <= mem_rdata;
        end
        // store data moves into the lane of the address loaded alongside it
        if (load_data_out) begin
            mem_wdata <= rs2_out << {marmux_out[1:0], 3'b000};
        end
    end

    assign mar_low  = mem_address[1:0];
    assign pc_plus4 = pc_out + 32'd4;

    // loaded byte or half brought down to bit 0
    assign ld_shift = mdr_out >> {mar_low, 3'b000};

    always_comb begin
        unique case (pcmux_sel)
            pcmux_pc_plus4: pcmux_out = pc_plus4;
            pcmux_alu_out:  pcmux_out = alu_out;
            pcmux_alu_mod2: pcmux_out = alu_out & 32'hffff_fffe;
            default:        pcmux_out = pc_plus4;
        endcase

        unique case (marmux_sel)
            marmux_pc_out:  marmux_out = pc_out;
            marmux_alu_out: marmux_out = alu_out;
        endcase

        unique case (cmpmux_sel)
            cmpmux_rs2_out: cmpmux_out = rs2_out;
            cmpmux_i_imm:   cmpmux_out = i_imm;
        endcase

        unique case (alumux1_sel)
            alumux1_rs1_out: alumux1_out = rs1_out;
            alumux1_pc_out:  alumux1_out = pc_out;
        endcase

        unique case (alumux2_sel)
            alumux2_i_imm:   alumux2_out = i_imm;
            alumux2_u_imm:   alumux2_out = u_imm;
            alumux2_b_imm:   alumux2_out = b_imm;
            alumux2_s_imm:   alumux2_out = s_imm;
            alumux2_j_imm:   alumux2_out = j_imm;
            alumux2_rs2_out: alumux2_out = rs2_out;
            default:         alumux2_out = i_imm;
        endcase

        unique case (regfilemux_sel)
            regfilemux_alu_out:  regfilemux_out = alu_out;
            regfilemux_br_en:    regfilemux_out = {31'b0, br_en};
            regfilemux_u_imm:    regfilemux_out = u_imm;
            regfilemux_lw:       regfilemux_out = mdr_out;
            regfilemux_pc_plus4: regfilemux_out = pc_plus4;
            regfilemux_lb:       regfilemux_out = {{24{ld_shift[7]}}, ld_shift[7:0]};
            regfilemux_lbu:      regfilemux_out = {24'b0, ld_shift[7:0]};
            regfilemux_lh:       regfilemux_out = {{16{ld_shift[15]}}, ld_shift[15:0]};
            regfilemux_lhu:      regfilemux_out = {16'b0, ld_shift[15:0]};
            default:             regfilemux_out = alu_out;
        endcase
    end

endmodule : datapath

/* logic/ir.sv */
module ir
import rv32i_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  rv32i_word   in,
    output rv32i_opcode opcode,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output rv32i_reg    rs1,
    output rv32i_reg    rs2,
    output rv32i_reg    rd,
    output rv32i_word   i_imm,
    output rv32i_word   s_imm,
    output rv32i_word   b_imm,
    output rv32i_word   u_imm,
    output rv32i_word   j_imm
);

    rv32i_word data;

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (load) begin
            data <= in;
        end
    end

    // field slices
    assign opcode = rv32i_opcode'(data[6:0]);
    assign funct3 = data[14:12];
    assign funct7 = data[31:25];
    assign rs1    = data[19:15];
    assign rs2    = data[24:20];
    assign rd     = data[11:7];

    // immediates, all sign extended from bit 31
    assign i_imm = {{21{data[31]}}, data[30:20]};
    assign s_imm = {{21{data[31]}}, data[30:25], data[11:7]};
    assign b_imm = {{20{data[31]}}, data[7], data[30:25], data[11:8], 1'b0};
    assign u_imm = {data[31:12], 12'h000};
    assign j_imm = {{12{data[31]}}, data[19:12], data[20], data[30:21], 1'b0};

endmodule : ir

/* logic/regfile.sv */
module regfile
import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  rv32i_word in,
    input  rv32i_reg  src_a,
    input  rv32i_reg  src_b,
    input  rv32i_reg  dest,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);

    rv32i_word data [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                data[i] <= '0;
            end
        end else if (load && dest != 5'd0) begin
            data[dest] <= in;
        end
    end

    // reads see the old value in a write cycle
    assign reg_a = (src_a == 5'd0) ? '0 : data[src_a];
    assign reg_b = (src_b == 5'd0) ? '0 : data[src_b];

endmodule : regfile

/* logic/rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // encodings line up with arith funct3 wherever the two share an operation
    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add, sll, slt, sltu, axor, sr, aor, aand
    } arith_funct3_t;

    // mux selects, literals carry the mux name so they stay unique
    typedef enum logic [1:0] {
        pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2
    } pcmux_sel_t;

    typedef enum logic {
        alumux1_rs1_out, alumux1_pc_out
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm,
        alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm,
        regfilemux_lw, regfilemux_pc_plus4, regfilemux_lb,
        regfilemux_lbu, regfilemux_lh, regfilemux_lhu
    } regfilemux_sel_t;

    typedef enum logic {
        marmux_pc_out, marmux_alu_out
    } marmux_sel_t;

    typedef enum logic {
        cmpmux_rs2_out, cmpmux_i_imm
    } cmpmux_sel_t;

    typedef enum logic [3:0] {
        fetch1, fetch2, fetch3, decode,
        s_imm, s_reg, s_lui, s_auipc, s_br, s_jal, s_jalr,
        calc_addr, ld1, ld2, st1
    } ctrl_state_t;

endpackage : rv32i_pkg

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

/* tb/cpu_golden.txt */
// words 0x000-0x0ff: memory image from 0x40000000 (program, data word at 0x300)
// 0x100: instruction count, store count; then records of address, data, byte enable
@000
400000B7 FFB00113 00300193 40218233 2040A023 403152B3 2050A223 00312333
003133B3 00431413 00746433 0F044413 2080A423 00001497 01C15513 00A484B3
2090A623 00310463 00158593 00318463 00258593 00311463 00458593 00319463
00858593 00314463 01058593 0021C463 02058593 00315463 04058593 0021D463
08058593 00316463 10058593 0021E463 20058593 0021F463 40058593 00317463
7FF58593 20B0A823 0080066F 00000613 0BD086E7 00000693 00000693 20C0AA23
20D0AC23 30008703 20E0AE23 30108703 22E0A023 30208703 22E0A223 30308703
22E0A423 3000C703 22E0A623 3010C703 22E0A823 3020C703 22E0AA23 3030C703
22E0AC23 30009703 22E0AE23 30209703 24E0A023 3000D703 24E0A223 3020D703
24E0A423 3000A703 24E0A623 2820A023 289080A3 28A081A3 28308023 28A08123
28909223 28209323 2800A783 24F0A823 2840A783 24F0AA23 2E90AE23 0000006F
@0C0
80FF7F01
@100
00000050 0000001E
40000200 00000008 0000000F
40000204 FFFFFFFF 0000000F
40000208 000000E0 0000000F
4000020C 40001043 0000000F
40000210 00000569 0000000F
40000214 400000AC 0000000F
40000218 400000B4 0000000F
4000021C 00000001 0000000F
40000220 0000007F 0000000F
40000224 FFFFFFFF 0000000F
40000228 FFFFFF80 0000000F
4000022C 00000001 0000000F
40000230 0000007F 0000000F
40000234 000000FF 0000000F
40000238 00000080 0000000F
4000023C 00007F01 0000000F
40000240 FFFF80FF 0000000F
40000244 00007F01 0000000F
40000248 000080FF 0000000F
4000024C 80FF7F01 0000000F
40000280 FFFFFFFB 0000000F
40000281 00104300 00000002
40000283 0F000000 00000008
40000280 00000003 00000001
40000282 000F0000 00000004
40000284 40001043 00000003
40000286 FFFB0000 0000000C
40000250 0F0F4303 0000000F
40000254 FFFB1043 0000000F
400002FC 40001043 0000000F

/* tb/cpu_props.sv */
module cpu_props
import rv32i_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        mem_read,
    input logic        mem_write,
    input logic        mem_resp,
    input logic [3:0]  mem_byte_enable,
    input ctrl_state_t state
);
    timeunit 1ns;
    timeprecision 1ps;

    // one request kind at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write)) else $error("mem_read and mem_write both high");

    // requests stay up until the response pulse
    read_held: assert property (@(posedge clk) disable iff (rst)
        (mem_read && !mem_resp) |=> mem_read) else $error("mem_read dropped before mem_resp");

    write_held: assert property (@(posedge clk) disable iff (rst)
        (mem_write && !mem_resp) |=> (mem_write && $stable(mem_byte_enable)))
        else $error("write request changed before mem_resp");

    // reset leaves the core in fetch1 with no request
    reset_state: assert property (@(posedge clk)
        rst |=> (state == fetch1 && !mem_read && !mem_write))
        else $error("state after reset is not an idle fetch1");

endmodule

bind control cpu_props i_props (
    .clk             (clk),
    .rst             (rst),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_resp        (mem_resp),
    .mem_byte_enable (mem_byte_enable),
    .state           (state)
);

/* tb/cpu_tb.sv */
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] base_addr = 32'h4000_0000;
    // last store of the program lands here
    localparam logic [31:0] done_addr = 32'h4000_02fc;
    localparam int mem_words = 1024;
    localparam int image_words = 256;
    // header at 0x100, store records right after it
    localparam int hdr_base = 256;
    localparam int rec_base = 258;
    localparam int runs = 2;

    logic        clk;
    logic        rst;
    logic [31:0] mem_rdata;
    logic        mem_resp;
    logic [31:0] mem_address;
    logic [31:0] mem_wdata;
    logic        mem_read;
    logic        mem_write;
    logic [3:0]  mem_byte_enable;

    logic [31:0] golden [0:511];
    logic [31:0] mem [0:mem_words-1];
    integer      seed;
    int          errors;
    int          checks;
    int          instr_count;
    int          store_count;
    int          rec_idx;
    int          wait_left;
    logic        busy;
    logic        first_req;
    logic        run_done;
    logic        loaded;

    cpu i_dut (
        .clk             (clk),
        .rst             (rst),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    always #10 clk = ~clk;

    // background pattern first, then the program and data words from the image
    task automatic load_image();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (base_addr + (i << 2)) ^ 32'h5a5a_5a5a;
        end
        for (int i = 0; i < image_words; i++) begin
            if (!$isunknown(golden[i])) begin
                mem[i] = golden[i];
            end
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // compare one store with the next expected record
    task automatic check_store();
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        logic [3:0]  exp_be;
        if (rec_idx >= store_count) begin
            errors++;
            $display("unexpected store to %h after all %0d expected stores", mem_address,
                     store_count);
        end else begin
            exp_addr = golden[rec_base + 3*rec_idx];
            exp_data = golden[rec_base + 3*rec_idx + 1];
            exp_be   = golden[rec_base + 3*rec_idx + 2][3:0];
            checks++;
            if (mem_address !== exp_addr) begin
                errors++;
                $display("FAIL t=%0t mem_address exp %h got %h", $time, exp_addr, mem_address);
            end
            if (mem_wdata !== exp_data) begin
                errors++;
                $display("FAIL t=%0t mem_wdata exp %h got %h", $time, exp_data, mem_wdata);
            end
            if (mem_byte_enable !== exp_be) begin
                errors++;
                $display("FAIL t=%0t mem_byte_enable exp %h got %h", $time, exp_be,
                         mem_byte_enable);
            end
            rec_idx++;
        end
        // the program is over once the core itself stores to the done address
        if (mem_address === done_addr) begin
            run_done = 1'b1;
        end
    endtask

    // one cycle of the memory model, called 1 ns after the rising edge
    task automatic serve_memory();
        logic [31:0] offset;
        mem_resp = 1'b0;
        if (mem_read || mem_write) begin
            if (!first_req) begin
                first_req = 1'b1;
                if (mem_write || mem_address !== base_addr) begin
                    errors++;
                    $display("first request after reset was not a read of the reset address");
                end
            end
            if (!busy) begin
                busy = 1'b1;
                // 1 to 3 wait cycles
                wait_left = $unsigned($random(seed)) % 3;
            end else if (wait_left > 0) begin
                wait_left--;
            end else begin
                offset = mem_address - base_addr;
                if (offset >= mem_words * 4) begin
                    errors++;
                    $display("access to %h falls outside the memory model", mem_address);
                end else if (mem_read) begin
                    mem_rdata = mem[offset >> 2];
                end else begin
                    check_store();
                    mem[offset >> 2] = merge_bytes(mem[offset >> 2], mem_wdata,
                                                   mem_byte_enable);
                end
                mem_resp = 1'b1;
                busy     = 1'b0;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        mem_rdata = '0;
        mem_resp  = 1'b0;
        seed      = 32'hc962;
        errors    = 0;
        checks    = 0;
        busy      = 1'b0;
        first_req = 1'b0;
        run_done  = 1'b0;
        loaded    = 1'b0;
        $readmemh("tb/cpu_golden.txt", golden);
        instr_count = golden[hdr_base];
        store_count = golden[hdr_base + 1];
        loaded      = 1'b1;
        // second run draws new wait lengths and must give the same stores
        for (int run = 0; run < runs; run++) begin
            load_image();
            rec_idx   = 0;
            run_done  = 1'b0;
            first_req = 1'b0;
            busy      = 1'b0;
            rst       = 1'b1;
            repeat (3) @(posedge clk);
            #1;
            rst      = 1'b0;
            mem_resp = 1'b0;
            while (!run_done) begin
                @(posedge clk);
                #1;
                serve_memory();
            end
            // let the last response be taken
            @(posedge clk);
            #1;
            mem_resp = 1'b0;
            if (rec_idx != store_count) begin
                errors++;
                $display("run %0d ended after %0d of %0d stores", run, rec_idx, store_count);
            end
        end
        $display("%0d errors in %0d store checks over %0d runs", errors, checks, runs);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // worst case of 40 cycles per instruction at the longest memory wait
    initial begin
        wait (loaded);
        repeat (runs * 40 * instr_count * 4) @(posedge clk);
        $display("timeout: program did not reach the done store in time");
        $display("Regression failed");
        $finish;
    end

endmodule
